//--- include/rv32_imm.svh
/*
 * RV32 immediate extraction macros
 * I, S, B, U and J formats, each sign-extended to a full word
 */

`ifndef RV32_IMM_SVH
`define RV32_IMM_SVH

// I-type: loads, ALU immediates, jalr
`define rv32_signext_i_imm(inst) {{20{inst[31]}}, inst[31:20]}

// S-type: stores, offset split around rd field
`define rv32_signext_s_imm(inst) {{20{inst[31]}}, inst[31:25], inst[11:7]}

// B-type: branch offset, bit 0 always zero
`define rv32_signext_b_imm(inst) \
    {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}

// U-type: lui/auipc, upper 20 bits
`define rv32_signext_u_imm(inst) {inst[31:12], 12'b0}

// J-type: jal offset, bit 0 always zero
`define rv32_signext_j_imm(inst) \
    {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}

`endif

//--- verilog/ex_pkg.sv
/*
 * Execute stage shared definitions
 * Word width, ALU function and operand select encodings
 * ID/EX and EX/MEM packet structs
 */

`default_nettype none

package ex_pkg;

    localparam int xlen = 32;                  // RV32, one word

    ////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////

    // ALU operation, 14 of 16 codes used
    typedef enum logic [3:0] {
        alu_add    = 4'h0,
        alu_sub    = 4'h1,
        alu_and    = 4'h2,
        alu_slt    = 4'h3,
        alu_sltu   = 4'h4,
        alu_or     = 4'h5,
        alu_xor    = 4'h6,
        alu_srl    = 4'h7,
        alu_sll    = 4'h8,
        alu_sra    = 4'h9,
        alu_mul    = 4'ha,                     // Low half, signed x signed
        alu_mulh   = 4'hb,                     // High half, signed x signed
        alu_mulhsu = 4'hc,                     // High half, signed x unsigned
        alu_mulhu  = 4'hd                      // High half, unsigned x unsigned
    } alu_func_e;

    // Operand A source, all four codes legal
    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_npc  = 2'h1,
        opa_is_pc   = 2'h2,
        opa_is_zero = 2'h3
    } opa_select_e;

    // Operand B source, codes 6 and 7 unused
    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } opb_select_e;

    ////////////////////////////////////////////////////////////////////
    // Pipeline packets
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;                  // pc + 4
        logic [xlen-1:0] inst;                 // Raw instruction word
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        opa_select_e     opa_select;
        opb_select_e     opb_select;
        alu_func_e       alu_func;
        logic            cond_branch;
        logic            uncond_branch;        // jal, jalr
        logic            rd_mem;
        logic            wr_mem;
        logic [4:0]      dest_reg_idx;
    } id_ex_packet_t;

    typedef struct packed {
        logic [xlen-1:0] npc;
        logic [xlen-1:0] alu_result;           // Also the branch target
        logic            take_branch;
        logic [xlen-1:0] rs2_value;            // Store data
        logic            rd_mem;
        logic            wr_mem;
        logic [4:0]      dest_reg_idx;
        logic [2:0]      mem_size;             // funct3 of load/store
    } ex_mem_packet_t;

endpackage

`default_nettype wire

//--- verilog/alu.sv
/*
 * Combinational ALU
 * RV32I arithmetic, logic, compare, shifts and RV32M multiplies
 */

`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [ex_pkg::xlen-1:0] opa,
    input  logic [ex_pkg::xlen-1:0] opb,
    input  ex_pkg::alu_func_e       func,
    output logic [ex_pkg::xlen-1:0] result
);

    import ex_pkg::*;

    logic signed [xlen-1:0]   signed_opa;
    logic signed [xlen-1:0]   signed_opb;
    logic [4:0]               shamt;
    logic signed [2*xlen-1:0] signed_mul;     // s x s
    logic signed [2*xlen-1:0] mixed_mul;      // s x u
    logic        [2*xlen-1:0] unsigned_mul;   // u x u

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign shamt      = opb[4:0];             // Upper shift bits ignored

    // Full-width products, single cycle
    assign signed_mul   = signed_opa * signed_opb;
    assign mixed_mul    = signed_opa * $signed({1'b0, opb}); // Zero bit keeps opb unsigned
    assign unsigned_mul = opa * opb;

    always_comb begin
        case (func)
            alu_add:    result = opa + opb;
            alu_sub:    result = opa - opb;
            alu_and:    result = opa & opb;
            alu_slt:    result = xlen'(signed_opa < signed_opb);
            alu_sltu:   result = xlen'(opa < opb);
            alu_or:     result = opa | opb;
            alu_xor:    result = opa ^ opb;
            alu_srl:    result = opa >> shamt;
            alu_sll:    result = opa << shamt;
            alu_sra:    result = signed_opa >>> shamt; // Sign fill
            alu_mul:    result = signed_mul[xlen-1:0];
            alu_mulh:   result = signed_mul[2*xlen-1:xlen];
            alu_mulhsu: result = mixed_mul[2*xlen-1:xlen];
            alu_mulhu:  result = unsigned_mul[2*xlen-1:xlen];
            default:    result = 32'hbad0_a1f0;         // Filler, unused codes
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/brcond.sv
/*
 * Branch condition
 * Compares two register values as selected by funct3
 */

`timescale 1ns/1ns
`default_nettype none

module brcond (
    input  logic [ex_pkg::xlen-1:0] rs1,
    input  logic [ex_pkg::xlen-1:0] rs2,
    input  logic [2:0]              func,   // funct3 of the branch
    output logic                    cond
);

    import ex_pkg::*;

    logic signed [xlen-1:0] signed_rs1;
    logic signed [xlen-1:0] signed_rs2;

    assign signed_rs1 = rs1;
    assign signed_rs2 = rs2;

    always_comb begin
        case (func)
            3'b000:  cond = (rs1 == rs2);               // beq
            3'b001:  cond = (rs1 != rs2);               // bne
            3'b100:  cond = (signed_rs1 <  signed_rs2); // blt
            3'b101:  cond = (signed_rs1 >= signed_rs2); // bge
            3'b110:  cond = (rs1 <  rs2);               // bltu
            3'b111:  cond = (rs1 >= rs2);               // bgeu
            default: cond = 1'b0;                       // 010, 011 not branches
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/stage_ex.sv
/*
 * Execute stage datapath
 * Operand muxes, ALU, branch condition and take-branch
 * Pass-through of memory and writeback fields
 */

`include "rv32_imm.svh"

`timescale 1ns/1ns
`default_nettype none

module stage_ex (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   valid,    // id_ex holds a live instruction
    input  ex_pkg::id_ex_packet_t  id_ex,
    output ex_pkg::ex_mem_packet_t ex_mem
);

    import ex_pkg::*;

    logic [xlen-1:0] opa_mux;
    logic [xlen-1:0] opb_mux;
    logic [xlen-1:0] alu_result;
    logic            branch_cond;

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.opa_select)
            opa_is_rs1:  opa_mux = id_ex.rs1_value;
            opa_is_npc:  opa_mux = id_ex.npc;
            opa_is_pc:   opa_mux = id_ex.pc;   // auipc, branch target
            default:     opa_mux = '0;         // opa_is_zero, lui
        endcase
    end

    always_comb begin
        case (id_ex.opb_select)
            opb_is_rs2:   opb_mux = id_ex.rs2_value;
            opb_is_i_imm: opb_mux = `rv32_signext_i_imm(id_ex.inst);
            opb_is_s_imm: opb_mux = `rv32_signext_s_imm(id_ex.inst);
            opb_is_b_imm: opb_mux = `rv32_signext_b_imm(id_ex.inst);
            opb_is_u_imm: opb_mux = `rv32_signext_u_imm(id_ex.inst);
            opb_is_j_imm: opb_mux = `rv32_signext_j_imm(id_ex.inst);
            default:      opb_mux = 32'hfeed_0b0b; // Shows an illegal select
        endcase
    end

    alu u_alu (
        .opa    (opa_mux),
        .opb    (opb_mux),
        .func   (id_ex.alu_func),
        .result (alu_result)
    );

    // Branch compare always on the register values
    brcond u_brcond (
        .rs1  (id_ex.rs1_value),
        .rs2  (id_ex.rs2_value),
        .func (id_ex.inst[14:12]),
        .cond (branch_cond)
    );

    //////////////////////////////////////////////////////////////////////
    // Output packet
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ex_mem.npc          = id_ex.npc;
        ex_mem.alu_result   = alu_result;
        // Jumps always, branches on condition
        ex_mem.take_branch  = id_ex.uncond_branch | (id_ex.cond_branch & branch_cond);
        ex_mem.rs2_value    = id_ex.rs2_value;
        ex_mem.rd_mem       = id_ex.rd_mem;
        ex_mem.wr_mem       = id_ex.wr_mem;
        ex_mem.dest_reg_idx = id_ex.dest_reg_idx;
        ex_mem.mem_size     = id_ex.inst[14:12]; // Byte, half, word + sign
    end

    // Decode upstream must never hand over unused encodings
    a_opb_legal : assert property (@(posedge clock) disable iff (!rst_n)
        valid |-> id_ex.opb_select inside {opb_is_rs2, opb_is_i_imm, opb_is_s_imm,
                                           opb_is_b_imm, opb_is_u_imm, opb_is_j_imm})
        else $error("stage_ex: illegal operand B select %0d", id_ex.opb_select);

    a_func_legal : assert property (@(posedge clock) disable iff (!rst_n)
        valid |-> id_ex.alu_func <= alu_mulhu)
        else $error("stage_ex: illegal ALU function %0d", id_ex.alu_func);

endmodule

`default_nettype wire

//--- verilog/pipe_reg.sv
/*
 * One-entry pipeline register with valid/ready handshake
 * Payload type set per instance
 */

`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // Room when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // Refill or drain
        end
    end

    // Payload only, no reset
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // Held entry must not change or vanish under back-pressure
    a_stall_stable : assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("pipe_reg: output changed while stalled");

endmodule

`default_nettype wire

//--- verilog/ex_unit_top.sv
/*
 * Execute unit top level
 * ID/EX register, execute stage, EX/MEM register
 */

`timescale 1ns/1ns
`default_nettype none

module ex_unit_top (
    input  logic                      clock,
    input  logic                      rst_n,
    // Decoded instruction in
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [ex_pkg::xlen-1:0]   in_pc,
    input  logic [ex_pkg::xlen-1:0]   in_npc,
    input  logic [ex_pkg::xlen-1:0]   in_inst,
    input  logic [ex_pkg::xlen-1:0]   in_rs1_value,
    input  logic [ex_pkg::xlen-1:0]   in_rs2_value,
    input  ex_pkg::opa_select_e       in_opa_select,
    input  ex_pkg::opb_select_e       in_opb_select,
    input  ex_pkg::alu_func_e         in_alu_func,
    input  logic                      in_cond_branch,
    input  logic                      in_uncond_branch,
    input  logic                      in_rd_mem,
    input  logic                      in_wr_mem,
    input  logic [4:0]                in_dest_reg_idx,
    // Result out, toward memory stage
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [ex_pkg::xlen-1:0]   out_npc,
    output logic [ex_pkg::xlen-1:0]   out_alu_result,
    output logic                      out_take_branch,
    output logic [ex_pkg::xlen-1:0]   out_rs2_value,
    output logic                      out_rd_mem,
    output logic                      out_wr_mem,
    output logic [4:0]                out_dest_reg_idx,
    output logic [2:0]                out_mem_size
);

    import ex_pkg::*;

    id_ex_packet_t  id_ex_in;
    id_ex_packet_t  id_ex_q;
    ex_mem_packet_t ex_mem_d;
    ex_mem_packet_t ex_mem_q;
    logic           ex_valid;   // u_id_ex holds an instruction
    logic           ex_ready;   // u_ex_mem can take it

    assign id_ex_in = '{pc: in_pc, npc: in_npc, inst: in_inst,
                        rs1_value: in_rs1_value, rs2_value: in_rs2_value,
                        opa_select: in_opa_select, opb_select: in_opb_select,
                        alu_func: in_alu_func, cond_branch: in_cond_branch,
                        uncond_branch: in_uncond_branch, rd_mem: in_rd_mem,
                        wr_mem: in_wr_mem, dest_reg_idx: in_dest_reg_idx};

    pipe_reg #(.payload_t(id_ex_packet_t)) u_id_ex (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (id_ex_in),
        .in_ready  (in_ready),
        .out_valid (ex_valid),
        .out_data  (id_ex_q),
        .out_ready (ex_ready)
    );

    stage_ex u_stage_ex (
        .clock  (clock),
        .rst_n  (rst_n),
        .valid  (ex_valid),
        .id_ex  (id_ex_q),
        .ex_mem (ex_mem_d)
    );

    pipe_reg #(.payload_t(ex_mem_packet_t)) u_ex_mem (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (ex_valid),
        .in_data   (ex_mem_d),
        .in_ready  (ex_ready),
        .out_valid (out_valid),
        .out_data  (ex_mem_q),
        .out_ready (out_ready)
    );

    // Unpack result
    assign out_npc          = ex_mem_q.npc;
    assign out_alu_result   = ex_mem_q.alu_result;
    assign out_take_branch  = ex_mem_q.take_branch;
    assign out_rs2_value    = ex_mem_q.rs2_value;
    assign out_rd_mem       = ex_mem_q.rd_mem;
    assign out_wr_mem       = ex_mem_q.wr_mem;
    assign out_dest_reg_idx = ex_mem_q.dest_reg_idx;
    assign out_mem_size     = ex_mem_q.mem_size;

endmodule

`default_nettype wire

//--- tests/ex_unit_tb.sv
/*
 * Testbench for the execute unit
 * Random decoded instructions, reference model queue, checking assertions
 * Back-pressure on out_ready, timeout and result line
 */

`include "rv32_imm.svh"

`timescale 1ns/1ns
`default_nettype none

module ex_unit_tb;

    import ex_pkg::*;

    localparam int num_txn      = 400;
    localparam int reset_cycles = 10;
    localparam int cycle_limit  = num_txn * 4 + 1400;   // 4 cycles worst case each

    logic            clock;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    logic [31:0]     in_pc;
    logic [31:0]     in_npc;
    logic [31:0]     in_inst;
    logic [31:0]     in_rs1_value;
    logic [31:0]     in_rs2_value;
    opa_select_e     in_opa_select;
    opb_select_e     in_opb_select;
    alu_func_e       in_alu_func;
    logic            in_cond_branch;
    logic            in_uncond_branch;
    logic            in_rd_mem;
    logic            in_wr_mem;
    logic [4:0]      in_dest_reg_idx;
    logic            out_valid;
    logic            out_ready;
    logic [31:0]     out_npc;
    logic [31:0]     out_alu_result;
    logic            out_take_branch;
    logic [31:0]     out_rs2_value;
    logic            out_rd_mem;
    logic            out_wr_mem;
    logic [4:0]      out_dest_reg_idx;
    logic [2:0]      out_mem_size;
    logic [106:0]    out_bundle;               // All out_ fields, for hold check

    integer          seed;
    int              cycles          = 0;
    int              accepted        = 0;
    int              produced        = 0;
    int              exp_count       = 0;
    int              value_errors    = 0;
    int              protocol_errors = 0;
    logic            in_xfer         = 1'b0;   // Transfer at the coming edge
    logic            out_xfer        = 1'b0;
    ex_mem_packet_t  exp_q[$];                 // Expected results, oldest first
    ex_mem_packet_t  exp_head;

    ex_unit_top DUT (.*);

    assign out_bundle = {out_npc, out_alu_result, out_take_branch, out_rs2_value,
                         out_rd_mem, out_wr_mem, out_dest_reg_idx, out_mem_size};

    always #2 clock = ~clock;                  // 4 ns period

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu_model(alu_func_e f, logic [31:0] a, logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] wide;
        sa = {{32{a[31]}}, a};                 // Sign-extended copies
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        wide = 64'b0;
        case (f)
            alu_add:    wide[31:0] = a + b;
            alu_sub:    wide[31:0] = a + ~b + 32'd1;
            alu_and:    wide[31:0] = a & b;
            alu_or:     wide[31:0] = a | b;
            alu_xor:    wide[31:0] = a ^ b;
            alu_slt:    wide[0] = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000); // Bias trick
            alu_sltu:   wide[0] = a < b;
            alu_srl:    wide[31:0] = a >> b[4:0];
            alu_sll:    wide[31:0] = a << b[4:0];
            alu_sra:    wide = sa >> b[4:0];   // Upper word supplies sign fill
            alu_mul:    wide = sa * sb;
            alu_mulh:   wide = (sa * sb) >> 32;
            alu_mulhsu: wide = (sa * ub) >> 32;
            alu_mulhu:  wide = (ua * ub) >> 32;
            default:    wide[31:0] = 32'hbad0_a1f0;
        endcase
        return wide[31:0];
    endfunction

    function automatic logic branch_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        logic lt_s;
        logic lt_u;
        lt_u = a < b;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt_s;
            3'b101:  return !lt_s;
            3'b110:  return lt_u;
            3'b111:  return !lt_u;
            default: return 1'b0;
        endcase
    endfunction

    // Expected packet from the inputs now on the ports
    function automatic ex_mem_packet_t expected_packet();
        ex_mem_packet_t p;
        logic [31:0]    a;
        logic [31:0]    b;
        case (in_opa_select)
            opa_is_rs1: a = in_rs1_value;
            opa_is_npc: a = in_npc;
            opa_is_pc:  a = in_pc;
            default:    a = 32'b0;
        endcase
        case (in_opb_select)
            opb_is_rs2:   b = in_rs2_value;
            opb_is_i_imm: b = `rv32_signext_i_imm(in_inst);
            opb_is_s_imm: b = `rv32_signext_s_imm(in_inst);
            opb_is_b_imm: b = `rv32_signext_b_imm(in_inst);
            opb_is_u_imm: b = `rv32_signext_u_imm(in_inst);
            default:      b = `rv32_signext_j_imm(in_inst);
        endcase
        p.npc          = in_npc;
        p.alu_result   = alu_model(in_alu_func, a, b);
        p.take_branch  = in_uncond_branch
                       | (in_cond_branch & branch_model(in_inst[14:12], in_rs1_value,
                                                        in_rs2_value));
        p.rs2_value    = in_rs2_value;
        p.rd_mem       = in_rd_mem;
        p.wr_mem       = in_wr_mem;
        p.dest_reg_idx = in_dest_reg_idx;
        p.mem_size     = in_inst[14:12];
        return p;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus and scoreboard bookkeeping
    //////////////////////////////////////////////////////////////////////

    task automatic draw_item();
        logic [31:0] pick;
        pick             = $random(seed);
        in_pc            = $random(seed) & ~32'h3;
        in_npc           = in_pc + 32'd4;
        in_inst          = $random(seed);
        in_rs1_value     = $random(seed);
        in_rs2_value     = ((pick[31:29] == 3'b0) ? in_rs1_value : $random(seed)); // Hits beq
        in_opa_select    = opa_select_e'(pick[1:0]);
        in_opb_select    = opb_select_e'(3'(pick[7:4] % 4'd6));   // Legal codes only
        in_alu_func      = alu_func_e'(4'(pick[15:8] % 8'd14));
        in_uncond_branch = (pick[17:16] == 2'd0);
        in_cond_branch   = (pick[17:16] == 2'd1) || (pick[17:16] == 2'd2);
        in_rd_mem        = pick[18];
        in_wr_mem        = pick[19];
        in_dest_reg_idx  = pick[24:20];
    endtask

    task automatic value_fail(string name, logic [31:0] exp, logic [31:0] act);
        value_errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic protocol_fail(string what);
        protocol_errors++;
        $display("Protocol error at %0t ns: %s", $time, what);
    endtask

    // Handshakes seen mid-cycle, where everything is settled
    always @(negedge clock) begin
        in_xfer  <= in_valid && in_ready;
        out_xfer <= out_valid && out_ready;
    end

    always @(posedge clock) begin
        if (out_xfer && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            produced++;
        end
        if (in_xfer) begin
            exp_q.push_back(expected_packet());   // Inputs still held until +1 ns
            accepted++;
        end
        if (exp_q.size() > 0)
            exp_head = exp_q[0];
        else
            exp_head = '0;
        exp_count = exp_q.size();
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d results seen",
                     cycles, produced, num_txn);
            $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        seed             = 32'h0e3b9f72;
        clock            = 1'b0;
        rst_n            = 1'b0;
        in_valid         = 1'b0;
        in_pc            = '0;
        in_npc           = '0;
        in_inst          = '0;
        in_rs1_value     = '0;
        in_rs2_value     = '0;
        in_opa_select    = opa_is_rs1;
        in_opb_select    = opb_is_rs2;
        in_alu_func      = alu_add;
        in_cond_branch   = 1'b0;
        in_uncond_branch = 1'b0;
        in_rd_mem        = 1'b0;
        in_wr_mem        = 1'b0;
        in_dest_reg_idx  = '0;
        out_ready        = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1 rst_n = 1'b1;
        while (produced < num_txn) begin
            @(posedge clock);
            #1;
            out_ready = ($random(seed) & 3) != 0;          // Low about a quarter
            if (accepted >= num_txn) begin
                in_valid = 1'b0;
            end else if (!in_valid || in_xfer) begin       // Hold while stalled
                in_valid = ($random(seed) & 7) != 0;
                if (in_valid)
                    draw_item();
            end
        end
        @(negedge clock);
        a_drained : assert (exp_count == 0 && accepted == num_txn)
            else protocol_fail("results still outstanding at the end of the run");
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_npc : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_npc == exp_head.npc)
        else value_fail("out_npc", exp_head.npc, out_npc);
    a_alu_result : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_alu_result == exp_head.alu_result)
        else value_fail("out_alu_result", exp_head.alu_result, out_alu_result);
    a_take_branch : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_take_branch == exp_head.take_branch)
        else value_fail("out_take_branch", 32'(exp_head.take_branch), 32'(out_take_branch));
    a_rs2_value : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_rs2_value == exp_head.rs2_value)
        else value_fail("out_rs2_value", exp_head.rs2_value, out_rs2_value);
    a_rd_mem : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_rd_mem == exp_head.rd_mem)
        else value_fail("out_rd_mem", 32'(exp_head.rd_mem), 32'(out_rd_mem));
    a_wr_mem : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_wr_mem == exp_head.wr_mem)
        else value_fail("out_wr_mem", 32'(exp_head.wr_mem), 32'(out_wr_mem));
    a_dest_reg_idx : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_dest_reg_idx == exp_head.dest_reg_idx)
        else value_fail("out_dest_reg_idx", 32'(exp_head.dest_reg_idx),
                        32'(out_dest_reg_idx));
    a_mem_size : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && out_ready) |-> out_mem_size == exp_head.mem_size)
        else value_fail("out_mem_size", 32'(exp_head.mem_size), 32'(out_mem_size));

    // Nothing comes out that was not accepted
    a_no_extra : assert property (@(negedge clock) disable iff (!rst_n)
        out_valid |-> exp_count > 0)
        else protocol_fail("out_valid high with no accepted input outstanding");

    a_hold : assert property (@(negedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_bundle)))
        else protocol_fail("outputs changed while out_ready was low");

    // Accepted at edge N, leaves at edge N+2 when not stalled at N+1
    a_latency : assert property (@(negedge clock) disable iff (!rst_n)
        ($past(in_valid && in_ready, 2) && $past(out_ready)) |-> out_valid)
        else protocol_fail("result not presented two edges after acceptance");

    a_in_reset : assert property (@(negedge clock)
        !rst_n |-> (!out_valid && in_ready))
        else protocol_fail("out_valid high or in_ready low during reset");
    // First clock edge out of reset, nothing offered yet
    a_after_reset : assert property (@(negedge clock)
        $rose(rst_n) |=> (!out_valid && in_ready))
        else protocol_fail("out_valid high or in_ready low right after reset");

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/ex_pkg.sv
verilog/alu.sv
verilog/brcond.sv
verilog/stage_ex.sv
verilog/pipe_reg.sv
verilog/ex_unit_top.sv
tests/ex_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module ex_unit_tb \
    -f sim.f \
    -o Vex_unit_tb

./obj_dir/Vex_unit_tb > sim.log 2>&1

if grep -q "^TEST RESULT: PASS$" sim.log; then
    echo "Simulation passed, see sim.log"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
